// ==== project.f ====
+incdir+source
source/mem_access_pkg.sv
source/pipe_pkg.sv
source/store_align.sv
source/byte_bank.sv
source/load_extract.sv
source/mem_stage.sv
verification/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mem_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f project.f \
    --top-module mem_stage_tb \
    -Mdir obj_dir \
    -o mem_stage_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/mem_stage_sim)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "NO ERRORS"; then
    exit 0
fi

echo "simulation did not report a clean run"
exit 1

// ==== source/byte_bank.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module byte_bank (
    input  logic                       clk,
    input  logic                       rd_en,
    input  logic                       wr_en,
    input  logic [`MEM_INDEX_BITS-1:0] index,
    input  logic [7:0]                 wdata,
    output logic [7:0]                 rdata
);

    localparam int DEPTH = 1 << `MEM_INDEX_BITS;

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= wdata;
        end
    end

    // read-first, old byte when written on the same edge
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[index]; // holds while the stage is stalled
        end
    end

endmodule

`default_nettype wire

// ==== source/load_extract.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module load_extract (
    input  logic [`MEM_XLEN-1:0]       lane_bytes,
    input  logic [1:0]                 offset,
    input  mem_access_pkg::mem_width_t width,
    output logic [`MEM_XLEN-1:0]       load_data
);

    import mem_access_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = lane_bytes[offset * 8 +: 8];
    assign sel_half = offset[1] ? lane_bytes[31:16] : lane_bytes[15:0];

    always_comb begin
        case (width)
            MEM_BYTE:   load_data = {{(`MEM_XLEN - 8){sel_byte[7]}}, sel_byte};
            MEM_HALF:   load_data = {{(`MEM_XLEN - 16){sel_half[15]}}, sel_half};
            MEM_BYTE_U: load_data = {{(`MEM_XLEN - 8){1'b0}}, sel_byte};
            MEM_HALF_U: load_data = {{(`MEM_XLEN - 16){1'b0}}, sel_half};
            default:    load_data = lane_bytes; // lw
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

    `include "mem_params.svh"

    // funct3 codes of loads and stores
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_width_t;

    typedef logic [`MEM_LANES-1:0] lane_mask_t; // one bit per byte lane

    function automatic logic mem_is_unsigned(input mem_width_t width);
        return width[2];
    endfunction

    // natural alignment of an access at this byte offset
    function automatic logic mem_is_aligned(input mem_width_t width, input logic [1:0] offset);
        logic ok;
        case (width)
            MEM_HALF, MEM_HALF_U: ok = (offset[0] == 1'b0);
            MEM_WORD:             ok = (offset == 2'b00);
            default:              ok = 1'b1;
        endcase
        return ok;
    endfunction

endpackage

`default_nettype wire

// ==== source/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`default_nettype none

// data word width
`define MEM_XLEN 32

// byte lanes per word
`define MEM_LANES 4

// word index width, 256 words of data memory
`define MEM_INDEX_BITS 8

`default_nettype wire

`endif

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  pipe_pkg::ex_mem_t in_rec,
    output logic              in_ready,
    output logic              out_valid,
    output pipe_pkg::mem_wb_t out_rec,
    input  logic              out_ready
);

    import pipe_pkg::*;
    import mem_access_pkg::*;

    ex_mem_t                    held;
    logic                       accept;
    logic                       store_wen;
    logic [`MEM_INDEX_BITS-1:0] word_index;
    lane_mask_t                 lane_wen;
    logic [`MEM_XLEN-1:0]       lane_data;
    logic [`MEM_XLEN-1:0]       lane_bytes;
    logic [`MEM_XLEN-1:0]       load_data;

    assign in_ready   = !out_valid || out_ready;
    assign accept     = in_valid && in_ready;
    assign store_wen  = accept && in_rec.mem_write;
    assign word_index = in_rec.alu_result[`MEM_INDEX_BITS + 1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= in_rec;
        end
    end

    store_align store_align_i (
        .write_en   (store_wen),
        .width      (in_rec.width),
        .offset     (in_rec.alu_result[1:0]),
        .store_data (in_rec.store_data),
        .lane_wen   (lane_wen),
        .lane_data  (lane_data)
    );

    for (genvar lane = 0; lane < `MEM_LANES; lane++) begin : g_bank
        byte_bank bank_i (
            .clk   (clk),
            .rd_en (accept), // read at accept, data valid with out_valid
            .wr_en (lane_wen[lane]),
            .index (word_index),
            .wdata (lane_data[lane * 8 +: 8]),
            .rdata (lane_bytes[lane * 8 +: 8])
        );
    end

    load_extract load_extract_i (
        .lane_bytes (lane_bytes),
        .offset     (held.alu_result[1:0]),
        .width      (held.width),
        .load_data  (load_data)
    );

    assign out_rec = '{
        pc:         held.pc,
        inst:       held.inst,
        alu_result: held.alu_result,
        load_data:  held.mem_read ? load_data : '0,
        csr_value:  held.csr_value,
        csr_wen:    held.csr_wen,
        rd:         held.rd,
        mem_read:   held.mem_read,
        reg_wen:    held.reg_wen,
        jump:       held.jump
    };

    // misaligned accesses are not trapped in this stage
    a_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept && (in_rec.mem_read || in_rec.mem_write)
            |-> mem_is_aligned(in_rec.width, in_rec.alu_result[1:0])
    ) else $error("mem_stage: misaligned access at %h", in_rec.alu_result);

    a_one_kind: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !(in_rec.mem_read && in_rec.mem_write)
    ) else $error("mem_stage: load and store in one record");

    // stalled output keeps valid, record and load data
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rec)
    ) else $error("mem_stage: output changed while stalled");

endmodule

`default_nettype wire

// ==== source/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    `include "mem_params.svh"

    // record handed over by execute
    typedef struct packed {
        logic [31:0]              pc;
        logic [31:0]              inst;
        logic [`MEM_XLEN-1:0]     alu_result;  // address for loads and stores
        logic [`MEM_XLEN-1:0]     store_data;
        logic [31:0]              csr_value;
        logic [3:0]               csr_wen;
        logic [4:0]               rd;
        mem_access_pkg::mem_width_t width;
        logic                     mem_read;
        logic                     mem_write;
        logic                     reg_wen;
        logic                     jump;
    } ex_mem_t;

    // record handed to write-back
    typedef struct packed {
        logic [31:0]          pc;
        logic [31:0]          inst;
        logic [`MEM_XLEN-1:0] alu_result;
        logic [`MEM_XLEN-1:0] load_data;  // zero unless mem_read
        logic [31:0]          csr_value;
        logic [3:0]           csr_wen;
        logic [4:0]           rd;
        logic                 mem_read;
        logic                 reg_wen;
        logic                 jump;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== source/store_align.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module store_align (
    input  logic                       write_en,
    input  mem_access_pkg::mem_width_t width,
    input  logic [1:0]                 offset,
    input  logic [`MEM_XLEN-1:0]       store_data,
    output mem_access_pkg::lane_mask_t lane_wen,
    output logic [`MEM_XLEN-1:0]       lane_data
);

    import mem_access_pkg::*;

    lane_mask_t mask;

    always_comb begin
        case (width)
            MEM_BYTE: begin
                mask      = lane_mask_t'(1) << offset;
                lane_data = {`MEM_LANES{store_data[7:0]}}; // byte in every lane
            end
            MEM_HALF: begin
                mask      = lane_mask_t'(2'b11) << {offset[1], 1'b0};
                lane_data = {(`MEM_LANES / 2){store_data[15:0]}};
            end
            MEM_WORD: begin
                mask      = '1;
                lane_data = store_data;
            end
            default: begin
                mask      = '0; // unsigned codes are loads only
                lane_data = store_data;
            end
        endcase
    end

    assign lane_wen = write_en ? mask : '0;

    // a store never carries an unsigned width code
    always_comb begin
        assert (!(write_en && mem_is_unsigned(width)))
            else $error("store_align: store with unsigned width %0d", width);
    end

endmodule

`default_nettype wire

// ==== verification/mem_stage_tb.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module mem_stage_tb;

    import pipe_pkg::*;
    import mem_access_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int unsigned RNG_SEED   = 32'hd18c_9b9a;
    localparam int          ADDR_BITS  = `MEM_INDEX_BITS + 2;
    localparam int          DEPTH      = 1 << `MEM_INDEX_BITS;
    localparam int          LANE_WORDS = 16;
    localparam int          PASS_OPS   = 64;
    localparam int          MIX_OPS    = 300;
    localparam int          MAX_STALL  = 4;
    localparam int          TOTAL_OPS  = 2 * DEPTH + LANE_WORDS * 24 + PASS_OPS + MIX_OPS;
    localparam longint      TIMEOUT_NS = longint'(TOTAL_OPS * (MAX_STALL + 4) + 50) * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    ex_mem_t in_rec;
    logic    in_ready;
    logic    out_valid;
    mem_wb_t out_rec;
    logic    out_ready;

    logic [7:0]  model_mem [1 << ADDR_BITS]; // byte-addressed reference memory
    mem_wb_t     exp_q [$];
    mem_wb_t     exp_head;
    int          exp_count;
    int          n_in;
    int          n_out;
    logic        took_in;
    logic        took_out;
    ex_mem_t     in_snap;
    logic        stall_mode;
    int          stall_left;
    int unsigned rng_state;

    mem_stage mem_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_rec    (in_rec),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_rec   (out_rec),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    initial begin
        #(TIMEOUT_NS);
        fail_run("Timeout: the stage stopped moving records before the tests finished");
    end

    function automatic logic [7:0] byte_at(input logic [31:0] addr);
        return model_mem[addr[ADDR_BITS-1:0]];
    endfunction

    task automatic put_byte(input logic [31:0] addr, input logic [7:0] value);
        model_mem[addr[ADDR_BITS-1:0]] = value;
    endtask

    task automatic model_store(input logic [31:0] addr, input mem_width_t width,
                               input logic [31:0] data);
        put_byte(addr, data[7:0]);
        if (width == MEM_HALF || width == MEM_WORD) put_byte(addr + 32'd1, data[15:8]);
        if (width == MEM_WORD) begin
            put_byte(addr + 32'd2, data[23:16]);
            put_byte(addr + 32'd3, data[31:24]);
        end
    endtask

    function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_width_t width);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = byte_at(addr);
        b1 = byte_at(addr + 32'd1);
        case (width)
            MEM_BYTE:   return {{24{b0[7]}}, b0};
            MEM_HALF:   return {{16{b1[7]}}, b1, b0};
            MEM_BYTE_U: return {24'h0, b0};
            MEM_HALF_U: return {16'h0, b1, b0};
            default:    return {byte_at(addr + 32'd3), byte_at(addr + 32'd2), b1, b0};
        endcase
    endfunction

    task automatic push_expected(input ex_mem_t r);
        mem_wb_t e;
        if (r.mem_write) model_store(r.alu_result, r.width, r.store_data);
        e.pc         = r.pc;
        e.inst       = r.inst;
        e.alu_result = r.alu_result;
        e.load_data  = r.mem_read ? model_load(r.alu_result, r.width) : '0;
        e.csr_value  = r.csr_value;
        e.csr_wen    = r.csr_wen;
        e.rd         = r.rd;
        e.mem_read   = r.mem_read;
        e.reg_wen    = r.reg_wen;
        e.jump       = r.jump;
        exp_q.push_back(e);
        n_in++;
    endtask

    // sample handshakes mid-cycle, update the model just after the edge
    task automatic next_cycle();
        @(negedge clk);
        took_in  = in_valid && in_ready;
        took_out = out_valid && out_ready;
        in_snap  = in_rec;
        @(posedge clk);
        #1;
        if (took_out && exp_q.size() != 0) begin
            exp_q.delete(0);
            n_out++;
        end
        if (took_in) push_expected(in_snap);
        exp_count = exp_q.size();
        if (exp_count != 0) exp_head = exp_q[0];
        if (!stall_mode) begin
            out_ready = 1'b1;
        end else if (stall_left > 0) begin
            out_ready = 1'b0;
            stall_left--;
        end else begin
            out_ready  = 1'b1;
            stall_left = int'($urandom_range(0, MAX_STALL));
        end
    endtask

    task automatic send(input ex_mem_t rec);
        in_valid = 1'b1;
        in_rec   = rec;
        do begin
            next_cycle();
        end while (!took_in);
        in_valid = 1'b0;
    endtask

    function automatic ex_mem_t random_alu_op();
        ex_mem_t r;
        r.pc         = $urandom;
        r.inst       = $urandom;
        r.alu_result = $urandom;
        r.store_data = $urandom;
        r.csr_value  = $urandom;
        r.csr_wen    = 4'($urandom);
        r.rd         = 5'($urandom);
        r.width      = MEM_WORD;
        r.mem_read   = 1'b0;
        r.mem_write  = 1'b0;
        r.reg_wen    = 1'($urandom);
        r.jump       = 1'($urandom);
        return r;
    endfunction

    function automatic ex_mem_t memory_op(input logic is_store, input mem_width_t width,
                                          input logic [31:0] addr, input logic [31:0] data);
        ex_mem_t r;
        r            = random_alu_op();
        r.alu_result = addr;
        r.store_data = data;
        r.width      = width;
        r.mem_read   = !is_store;
        r.mem_write  = is_store;
        r.reg_wen    = !is_store;
        r.jump       = 1'b0;
        return r;
    endfunction

    function automatic logic [31:0] aligned_addr(input mem_width_t width);
        logic [31:0] a;
        a = $urandom;
        if (width == MEM_WORD) a[1:0] = 2'b00;
        if (width == MEM_HALF || width == MEM_HALF_U) a[0] = 1'b0;
        return a;
    endfunction

    function automatic mem_width_t random_load_width();
        case ($urandom_range(0, 4))
            0:       return MEM_BYTE;
            1:       return MEM_HALF;
            2:       return MEM_BYTE_U;
            3:       return MEM_HALF_U;
            default: return MEM_WORD;
        endcase
    endfunction

    function automatic mem_width_t random_store_width();
        case ($urandom_range(0, 2))
            0:       return MEM_BYTE;
            1:       return MEM_HALF;
            default: return MEM_WORD;
        endcase
    endfunction

    a_reset_state: assert property (
        @(posedge clk) !rst_n |=> !out_valid && in_ready
    ) else fail_run($sformatf("Mismatch at %0t: stage not idle after reset", $time));

    a_idle_ready: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |-> in_ready
    ) else fail_run($sformatf("Mismatch at %0t: in_ready low with empty output", $time));

    a_stall_ready: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid && !out_ready |-> !in_ready
    ) else fail_run($sformatf("Mismatch at %0t: in_ready high while stalled", $time));

    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rec)
    ) else fail_run($sformatf("Mismatch at %0t: output record changed while stalled", $time));

    a_out_expected: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid && out_ready |-> exp_count != 0
    ) else fail_run("A record came out of the stage that was never accepted");

    a_out_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && exp_count != 0 |-> out_rec == exp_head
    ) else fail_run($sformatf("Mismatch at %0t: out_rec %h, expected %h",
                              $time, out_rec, exp_head));

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [7:0]  bval;
        logic [15:0] hval;
        mem_width_t  width;
        rng_state  = $urandom(RNG_SEED);
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_rec     = '0;
        out_ready  = 1'b1;
        stall_mode = 1'b0;
        stall_left = 0;
        exp_count  = 0;
        exp_head   = '0;
        n_in       = 0;
        n_out      = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < DEPTH; i++) begin // every word gets a known value
            addr = $urandom;
            addr[ADDR_BITS-1:0] = {(ADDR_BITS - 2)'(i), 2'b00};
            send(memory_op(1'b1, MEM_WORD, addr, $urandom));
        end
        for (int i = 0; i < DEPTH; i++) begin
            addr = {(32 - ADDR_BITS)'(0), (ADDR_BITS - 2)'(i), 2'b00};
            send(memory_op(1'b0, MEM_WORD, addr, $urandom));
        end

        for (int w = 0; w < LANE_WORDS; w++) begin
            addr = aligned_addr(MEM_WORD);
            for (int off = 0; off < 4; off++) begin
                bval    = 8'($urandom);
                bval[7] = off[0] ^ w[0]; // both signs
                data    = {24'($urandom), bval};
                send(memory_op(1'b1, MEM_BYTE, {addr[31:2], 2'(off)}, data));
                send(memory_op(1'b0, MEM_BYTE, {addr[31:2], 2'(off)}, $urandom));
                send(memory_op(1'b0, MEM_BYTE_U, {addr[31:2], 2'(off)}, $urandom));
                send(memory_op(1'b0, MEM_WORD, addr, $urandom));
            end
            for (int off = 0; off < 4; off += 2) begin
                hval     = 16'($urandom);
                hval[15] = off[1] ^ w[0];
                data     = {16'($urandom), hval};
                send(memory_op(1'b1, MEM_HALF, {addr[31:2], 2'(off)}, data));
                send(memory_op(1'b0, MEM_HALF, {addr[31:2], 2'(off)}, $urandom));
                send(memory_op(1'b0, MEM_HALF_U, {addr[31:2], 2'(off)}, $urandom));
                send(memory_op(1'b0, MEM_WORD, addr, $urandom));
            end
        end

        for (int i = 0; i < PASS_OPS; i++) begin
            send(random_alu_op());
        end

        stall_mode = 1'b1;
        for (int i = 0; i < MIX_OPS; i++) begin
            repeat ($urandom_range(0, 2)) next_cycle(); // idle gaps
            case ($urandom_range(0, 2))
                0: begin
                    width = random_load_width();
                    send(memory_op(1'b0, width, aligned_addr(width), $urandom));
                end
                1: begin
                    width = random_store_width();
                    send(memory_op(1'b1, width, aligned_addr(width), $urandom));
                end
                default: send(random_alu_op());
            endcase
        end

        stall_mode = 1'b0;
        for (int i = 0; i < MAX_STALL + 4 && exp_q.size() != 0; i++) begin
            next_cycle();
        end
        repeat (3) next_cycle();

        if (n_out != n_in) begin
            fail_run($sformatf("Records were lost: %0d accepted, %0d delivered", n_in, n_out));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
